// ==== build.f ====
+incdir+include
rtl/tcb_lite_pkg.sv
rtl/tcb_dump_pkg.sv
rtl/tcb_lite_lane_map.sv
rtl/tcb_lite_mem_array.sv
rtl/tcb_dump_counter.sv
rtl/tcb_dump_fsm.sv
rtl/tcb_lite_mem_top.sv
tb/tcb_lite_mem_checker.sv
tb/tcb_lite_mem_tb.sv

// ==== Makefile ====
# Verilator build and run for the tcb-lite memory testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tcb_lite_mem_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the verdict
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tcb_lite_mem_testdata.txt ====
# op adr/first siz/last byt/count data/again, all fields in hex
# w write, r read with expected rdt, d dump followed by e lines (adr data), i idle up to n cycles
w 000 2 0 11223344
w 004 2 0 55667788
r 000 2 0 11223344
r 004 2 0 55667788
i 5 0 0 0
w 008 2 0 d0c0b0a0
w 00c 2 0 e3e2e1e0
w 009 0 0 000000a5
w 00b 1 0 0000beef
r 00a 2 0 e1beefc0
r 009 0 0 000000a5
r 00b 1 0 0000beef
r 00d 1 0 0000e2e1
w 3fc 2 0 01020304
w 3ff 2 0 cafef00d
i 3 0 0 0
r 000 2 0 11cafef0
r 3ff 1 0 0000f00d
d 00 03 4 0
e 00 11cafef0 0 0
e 01 55667788 0 0
e 02 efc0a5a0 0 0
e 03 e3e2e1be 0 0
d ff 01 3 1
e ff 0d020304 0 0
e 00 11cafef0 0 0
e 01 55667788 0 0

// ==== tb/tcb_lite_mem_tb.sv ====
// testbench for the tcb-lite memory with bus and dump sequences from a data file

`timescale 1ns/10ps
`include "tcb_lite_settings.svh"

module tcb_lite_mem_tb
    import tcb_lite_pkg::*;
();

    localparam int    W         = `TCB_BYT * 8;
    localparam int    RW        = `TCB_ROW_W;
    localparam int    PERIOD    = 4;
    localparam string DATA_FILE = "tb/tcb_lite_mem_testdata.txt";

    logic                  tcb = 1'b0;
    logic                  rst_n;
    logic                  vld;
    logic                  wen;
    logic [`TCB_ADR_W-1:0] adr;
    tcb_siz_e              siz;
    logic [`TCB_BYT-1:0]   byt;
    logic [W-1:0]          wdt;
    logic                  rsp_vld;
    logic [W-1:0]          rdt;
    logic                  dump_start;
    logic [RW-1:0]         dump_first;
    logic [RW-1:0]         dump_last;
    logic                  dump_busy;
    logic                  dump_vld;
    logic [RW-1:0]         dump_adr;
    logic [W-1:0]          dump_dat;
    logic                  dump_done;

    // current data line
    int          fd;
    int          line_cnt = 0;
    bit          lines_counted = 1'b0;
    integer      seed = 32'h34f5;
    logic [7:0]  op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    bit          eof;

    tcb_lite_mem_top dut (.*);

    initial begin
        forever #(PERIOD / 2) tcb = ~tcb;
    end

    // run length scales with the data file
    initial begin
        wait (lines_counted);
        #(PERIOD * line_cnt * 40);
        $display("watchdog expired before the data file was finished");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic compare_value(input string name, input logic [W-1:0] act,
                                 input logic [W-1:0] exp);
        if (act !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, act, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    // next operation line with comment lines skipped
    task automatic fetch_line();
        logic [8*128-1:0] rest;
        int               rc;
        bit               found;
        found = 1'b0;
        eof   = 1'b0;
        while (!found && !eof) begin
            op = '0;
            rc = $fscanf(fd, "%s", op);
            if (rc != 1) begin
                eof = 1'b1;
            end else if (op == "#") begin
                rc = $fgets(rest, fd);
            end else if ($fscanf(fd, "%h %h %h %h", f1, f2, f3, f4) != 4) begin
                abort_run("malformed line in the data file");
            end else begin
                found = 1'b1;
            end
        end
    endtask

    // one bus transfer from falling edge to falling edge
    task automatic bus_request(input logic w, input logic [31:0] a, input logic [31:0] s,
                               input logic [31:0] b, input logic [31:0] d);
        adr = a[`TCB_ADR_W-1:0];
        siz = tcb_siz_e'(s[1:0]);
        byt = b[`TCB_BYT-1:0];
        wdt = w ? d : '0;
        wen = w;
        vld = 1'b1;
        @(negedge tcb);
        vld = 1'b0;
        wen = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a, input logic [31:0] s,
                            input logic [31:0] b, input logic [31:0] exp);
        bus_request(1'b0, a, s, b, '0);
        // registered response due one cycle after the request
        compare_value("rsp_vld", W'(rsp_vld), W'(1));
        compare_value("rdt", rdt, exp);
    endtask

    task automatic run_dump(input logic [31:0] first, input logic [31:0] last,
                            input logic [31:0] count, input logic [31:0] again);
        int got;
        int n;
        dump_first = first[RW-1:0];
        dump_last  = last[RW-1:0];
        dump_start = 1'b1;
        @(negedge tcb);
        // second start while busy with a one-word range
        dump_start = (again != 0);
        dump_last  = dump_first;
        compare_value("dump_busy", W'(dump_busy), W'(1));
        got = 0;
        n   = 0;
        while (got < int'(count)) begin
            if (n > int'(count) + 4) begin
                abort_run("dump stream ended before the expected word count");
            end else if (dump_vld) begin
                fetch_line();
                if (eof || op != "e") begin
                    abort_run("data file lists fewer dump words than the count");
                end else begin
                    compare_value("dump_adr", W'(dump_adr), f1);
                    compare_value("dump_dat", dump_dat, f2);
                    compare_value("dump_done", W'(dump_done), W'(got == int'(count) - 1));
                    got++;
                end
            end
            @(negedge tcb);
            dump_start = 1'b0;
            n++;
        end
        // run over and no extra word
        compare_value("dump_busy", W'(dump_busy), W'(0));
        compare_value("dump_vld", W'(dump_vld), W'(0));
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [8*128-1:0] rest;
        int               gap;
        rst_n      = 1'b0;
        vld        = 1'b0;
        wen        = 1'b0;
        adr        = '0;
        siz        = SIZ_1;
        byt        = '0;
        wdt        = '0;
        dump_start = 1'b0;
        dump_first = '0;
        dump_last  = '0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the data file");
        end
        while ($fgets(rest, fd) != 0) begin
            line_cnt++;
        end
        $fclose(fd);
        lines_counted = 1'b1;
        fd = $fopen(DATA_FILE, "r");
        repeat (10) @(negedge tcb);
        rst_n = 1'b1;
        fetch_line();
        while (!eof) begin
            case (op)
                "w": bus_request(1'b1, f1, f2, f3, f4);
                "r": bus_read(f1, f2, f3, f4);
                "d": run_dump(f1, f2, f3, f4);
                "i": begin
                    gap = ($random(seed) & 32'h7fff_ffff) % (f1 + 1);
                    repeat (gap) @(negedge tcb);
                end
                default: abort_run("unknown operation in the data file");
            endcase
            fetch_line();
        end
        $fclose(fd);
        $display("Test OK");
        $finish;
    end

endmodule : tcb_lite_mem_tb

// ==== tb/tcb_lite_mem_checker.sv ====
// protocol and timing assertions for the tcb-lite memory top level

`timescale 1ns/10ps
`include "tcb_lite_settings.svh"

module tcb_lite_mem_checker (
    input logic                  tcb,
    input logic                  rst_n,
    input logic                  vld,
    input logic                  wen,
    input logic                  rsp_vld,
    input logic                  dump_busy,
    input logic                  dump_vld,
    input logic                  dump_done,
    input logic [`TCB_ROW_W-1:0] dump_adr
);

    ////////////////////////////////////////
    // bus response timing
    ////////////////////////////////////////

    // response exactly one cycle after a read, never otherwise
    a_rsp_latency : assert property (
        @(posedge tcb) disable iff (!rst_n)
        $past(rst_n) |-> (rsp_vld == $past(vld && !wen))
    ) else $error("rsp_vld does not follow the read request by one cycle");

    ////////////////////////////////////////
    // dump stream
    ////////////////////////////////////////

    // words only inside a run
    a_dump_in_run : assert property (
        @(posedge tcb) disable iff (!rst_n)
        dump_vld |-> dump_busy
    ) else $error("dump_vld high while no dump run is active");

    // consecutive words, row index wraps
    a_dump_step : assert property (
        @(posedge tcb) disable iff (!rst_n)
        (dump_vld && !dump_done) |=>
            (dump_vld && dump_adr == `TCB_ROW_W'($past(dump_adr) + 1'b1))
    ) else $error("dump_adr did not advance by one between words");

    // control outputs cleared by reset
    a_reset_low : assert property (
        @(posedge tcb)
        !rst_n |=> (!rsp_vld && !dump_vld && !dump_done && !dump_busy)
    ) else $error("control output high in the cycle after reset");

endmodule : tcb_lite_mem_checker

bind tcb_lite_mem_top tcb_lite_mem_checker u_checker (.*);

// ==== rtl/tcb_lite_mem_top.sv ====
// tcb-lite byte-addressed memory with registered reads and a hardware dump engine

`timescale 1ns/10ps
`include "tcb_lite_settings.svh"

module tcb_lite_mem_top
    import tcb_lite_pkg::*;
(
    input  logic                    tcb,
    input  logic                    rst_n,
    // bus request
    input  logic                    vld,
    input  logic                    wen,
    input  logic [`TCB_ADR_W-1:0]   adr,
    input  tcb_siz_e                siz,
    input  logic [`TCB_BYT-1:0]     byt,
    input  logic [`TCB_BYT*8-1:0]   wdt,
    // bus response
    output logic                    rsp_vld,
    output logic [`TCB_BYT*8-1:0]   rdt,
    // dump control
    input  logic                    dump_start,
    input  logic [`TCB_ROW_W-1:0]   dump_first,
    input  logic [`TCB_ROW_W-1:0]   dump_last,
    output logic                    dump_busy,
    // dump stream
    output logic                    dump_vld,
    output logic [`TCB_ROW_W-1:0]   dump_adr,
    output logic [`TCB_BYT*8-1:0]   dump_dat,
    output logic                    dump_done
);

    ////////////////////////////////////////
    // bus path
    ////////////////////////////////////////

    logic [`TCB_BYT-1:0]                 bank_we;
    logic [`TCB_BYT-1:0][`TCB_ROW_W-1:0] bank_row;
    logic [`TCB_BYT-1:0][7:0]            bank_wdat;
    logic [`TCB_BYT-1:0]                 bank_re;
    logic [`TCB_BYT-1:0][7:0]            bank_rdat;

    // dump path
    logic                  load;
    logic                  step;
    logic                  dump_re;
    logic [`TCB_ROW_W-1:0] row;
    logic                  at_last;

    tcb_lite_lane_map u_lane_map (
        .tcb       (tcb),
        .rst_n     (rst_n),
        .vld       (vld),
        .wen       (wen),
        .adr       (adr),
        .siz       (siz),
        .byt       (byt),
        .wdt       (wdt),
        .bank_we   (bank_we),
        .bank_row  (bank_row),
        .bank_wdat (bank_wdat),
        .bank_re   (bank_re),
        .bank_rdat (bank_rdat),
        .rsp_vld   (rsp_vld),
        .rdt       (rdt)
    );

    tcb_lite_mem_array u_array (
        .tcb       (tcb),
        .bank_we   (bank_we),
        .bank_row  (bank_row),
        .bank_wdat (bank_wdat),
        .bank_re   (bank_re),
        .bank_rdat (bank_rdat),
        .dump_re   (dump_re),
        .dump_row  (row),
        .dump_rdat (dump_dat)
    );

    ////////////////////////////////////////
    // dump engine
    ////////////////////////////////////////

    tcb_dump_counter u_counter (
        .tcb     (tcb),
        .rst_n   (rst_n),
        .load    (load),
        .step    (step),
        .first   (dump_first),
        .last    (dump_last),
        .row     (row),
        .at_last (at_last)
    );

    tcb_dump_fsm u_fsm (
        .tcb        (tcb),
        .rst_n      (rst_n),
        .dump_start (dump_start),
        .at_last    (at_last),
        .load       (load),
        .step       (step),
        .dump_re    (dump_re),
        .dump_busy  (dump_busy),
        .dump_vld   (dump_vld),
        .dump_done  (dump_done)
    );

    // word index lined up with the array read latency
    always_ff @(posedge tcb) begin
        dump_adr <= row;
    end

endmodule : tcb_lite_mem_top

// ==== rtl/tcb_dump_fsm.sv ====
// dump sequencer FSM that runs one array read per cycle over a word range

`timescale 1ns/10ps

module tcb_dump_fsm
    import tcb_dump_pkg::*;
(
    input  logic tcb,
    input  logic rst_n,
    input  logic dump_start,
    // counter handshake
    input  logic at_last,
    output logic load,
    output logic step,
    // array read enable
    output logic dump_re,
    // status and word strobes
    output logic dump_busy,
    output logic dump_vld,
    output logic dump_done
);

    dump_state_e state;
    dump_state_e state_nxt;

    ////////////////////////////////////////
    // state transitions
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            DMP_IDLE: if (dump_start) state_nxt = DMP_READ;
            DMP_READ: if (at_last) state_nxt = DMP_LAST;
            DMP_LAST: state_nxt = DMP_IDLE;
            default:  state_nxt = DMP_IDLE;
        endcase
    end

    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            state <= DMP_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // start only counts while idle
    assign load      = (state == DMP_IDLE) && dump_start;
    assign dump_re   = (state == DMP_READ);
    assign step      = dump_re && !at_last;
    assign dump_busy = (state != DMP_IDLE);

    // strobes trail the read by the array latency
    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            dump_vld  <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            dump_vld  <= dump_re;
            dump_done <= dump_re && at_last;
        end
    end

endmodule : tcb_dump_fsm

// ==== rtl/tcb_dump_counter.sv ====
// dump word address counter with wraparound and a last-word flag

`timescale 1ns/10ps
`include "tcb_lite_settings.svh"

module tcb_dump_counter (
    input  logic                  tcb,
    input  logic                  rst_n,
    // control from the FSM
    input  logic                  load,
    input  logic                  step,
    // run range, word indices
    input  logic [`TCB_ROW_W-1:0] first,
    input  logic [`TCB_ROW_W-1:0] last,
    // current row and end flag
    output logic [`TCB_ROW_W-1:0] row,
    output logic                  at_last
);

    // end of range, held for the whole run
    logic [`TCB_ROW_W-1:0] last_q;

    // row wraps at the top of the array
    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            row <= '0;
        end else if (load) begin
            row <= first;
        end else if (step) begin
            row <= row + 1'b1;
        end
    end

    always_ff @(posedge tcb) begin
        if (load) begin
            last_q <= last;
        end
    end

    // a range with last below first runs through the wrap
    assign at_last = (row == last_q);

endmodule : tcb_dump_counter

// ==== rtl/tcb_lite_mem_array.sv ====
// byte-banked memory array with one write port, a bus read port and a dump read port

`timescale 1ns/10ps
`include "tcb_lite_settings.svh"

module tcb_lite_mem_array (
    input  logic                                tcb,
    // bus side
    input  logic [`TCB_BYT-1:0]                 bank_we,
    input  logic [`TCB_BYT-1:0][`TCB_ROW_W-1:0] bank_row,
    input  logic [`TCB_BYT-1:0][7:0]            bank_wdat,
    input  logic [`TCB_BYT-1:0]                 bank_re,
    output logic [`TCB_BYT-1:0][7:0]            bank_rdat,
    // dump side, one row across all banks
    input  logic                                dump_re,
    input  logic [`TCB_ROW_W-1:0]               dump_row,
    output logic [`TCB_BYT-1:0][7:0]            dump_rdat
);

    localparam int ROWS = `TCB_MEM_SIZE / `TCB_BYT;

    for (genvar k = 0; k < `TCB_BYT; k++) begin : g_bank

        // one byte lane of the memory
        logic [7:0] mem [0:ROWS-1];
        logic [7:0] bus_q;
        logic [7:0] dmp_q;

        always_ff @(posedge tcb) begin
            if (bank_we[k]) begin
                mem[bank_row[k]] <= bank_wdat[k];
            end
        end

        // bus read, holds its value while not enabled
        always_ff @(posedge tcb) begin
            if (bank_re[k]) begin
                bus_q <= mem[bank_row[k]];
            end
        end

        // dump read sees the old byte on a same-cycle write
        always_ff @(posedge tcb) begin
            if (dump_re) begin
                dmp_q <= mem[dump_row];
            end
        end

        assign bank_rdat[k] = bus_q;
        assign dump_rdat[k] = dmp_q;

    end

endmodule : tcb_lite_mem_array

// ==== rtl/tcb_lite_lane_map.sv ====
// tcb-lite lane mapper that rotates bus bytes onto memory banks and back

`timescale 1ns/10ps
`include "tcb_lite_settings.svh"

module tcb_lite_lane_map
    import tcb_lite_pkg::*;
(
    input  logic                                tcb,
    input  logic                                rst_n,
    // bus request
    input  logic                                vld,
    input  logic                                wen,
    input  logic [`TCB_ADR_W-1:0]               adr,
    input  tcb_siz_e                            siz,
    input  logic [`TCB_BYT-1:0]                 byt,
    input  logic [`TCB_BYT-1:0][7:0]            wdt,
    // bank side
    output logic [`TCB_BYT-1:0]                 bank_we,
    output logic [`TCB_BYT-1:0][`TCB_ROW_W-1:0] bank_row,
    output logic [`TCB_BYT-1:0][7:0]            bank_wdat,
    output logic [`TCB_BYT-1:0]                 bank_re,
    input  logic [`TCB_BYT-1:0][7:0]            bank_rdat,
    // bus response
    output logic                                rsp_vld,
    output logic [`TCB_BYT-1:0][7:0]            rdt
);

    localparam int LNW = $clog2(`TCB_BYT);

    // byte offset inside the word and the word row
    logic [LNW-1:0]        off;
    logic [`TCB_ROW_W-1:0] row;
    // number of bytes in a log-size transfer
    logic [LNW:0]          cnt;
    // per-bank select
    logic [`TCB_BYT-1:0]   sel;
    logic                  rd;
    // read context held for the response cycle
    logic [LNW-1:0]        rot_q;
    logic [`TCB_BYT-1:0]   sel_q;

    assign off = adr[LNW-1:0];
    assign row = adr[`TCB_ADR_W-1:LNW];
    assign cnt = (LNW+1)'(1) << siz;
    assign rd  = vld & ~wen;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    for (genvar k = 0; k < `TCB_BYT; k++) begin : g_bank
        // transfer byte that lands in bank k
        logic [LNW-1:0] idx;
        assign idx = LNW'(k) - off;
        if (`TCB_MODE == 0) begin : g_log
            assign sel[k]       = ({1'b0, idx} < cnt);
            assign bank_wdat[k] = wdt[idx];
        end else begin : g_byt
            assign sel[k]       = byt[k];
            assign bank_wdat[k] = wdt[k];
        end
        // lanes below the offset sit in the next word, wraps at the top
        assign bank_row[k] = (LNW'(k) < off) ? row + 1'b1 : row;
    end

    assign bank_we = {`TCB_BYT{vld & wen}} & sel;
    assign bank_re = {`TCB_BYT{rd}} & sel;

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= rd;
        end
    end

    // byte-enable lanes are not rotated
    always_ff @(posedge tcb) begin
        if (rd) begin
            rot_q <= (`TCB_MODE == 0) ? off : '0;
            sel_q <= sel;
        end
    end

    // rotate banks back onto bus lanes, unselected lanes read zero
    for (genvar j = 0; j < `TCB_BYT; j++) begin : g_lane
        logic [LNW-1:0] src;
        assign src    = LNW'(j) + rot_q;
        assign rdt[j] = sel_q[src] ? bank_rdat[src] : 8'h00;
    end

endmodule : tcb_lite_lane_map

// ==== rtl/tcb_dump_pkg.sv ====
// dump engine types for the memory hex-dump sequencer

package tcb_dump_pkg;

    ////////////////////////////////////////
    // dump sequencer states
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        // waiting for a start pulse
        DMP_IDLE = 2'd0,
        // one array read per cycle
        DMP_READ = 2'd1,
        // final word on its way out
        DMP_LAST = 2'd2
    } dump_state_e;

endpackage : tcb_dump_pkg

// ==== rtl/tcb_lite_pkg.sv ====
// tcb-lite bus types shared by the memory front end and its top level

package tcb_lite_pkg;

    ////////////////////////////////////////
    // transfer size
    ////////////////////////////////////////

    // log2 of the byte count of a transfer
    // only used in log-size mode
    typedef enum logic [1:0] {
        // single byte
        SIZ_1 = 2'd0,
        // halfword
        SIZ_2 = 2'd1,
        // full 32-bit word
        SIZ_4 = 2'd2
    } tcb_siz_e;

    // 2'd3 is not a legal size here
    // a request with it would map 8 bytes onto 4 lanes

endpackage : tcb_lite_pkg

// ==== include/tcb_lite_settings.svh ====
// tcb-lite memory build settings for bus width, address space and addressing mode

`ifndef TCB_LITE_SETTINGS_SVH
`define TCB_LITE_SETTINGS_SVH

// bytes per bus word
`define TCB_BYT 4

// byte address width
`define TCB_ADR_W 10

// memory size in bytes
`define TCB_MEM_SIZE (2**`TCB_ADR_W)

// bank row address width, word part of the byte address
`define TCB_ROW_W (`TCB_ADR_W - $clog2(`TCB_BYT))

// addressing mode
// 0 selects log-size transfers, 1 selects per-lane byte enables
`define TCB_MODE 0

`endif
